//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_eth_rx_check
SIM_ARGS  ?=
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --timing --assert -f project.f --top-module $(TOP) --Mdir $(OBJ_DIR)

# Fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

//--- eth_rx_check.sv
`timescale 1ns/1ns

module eth_rx_check
    import eth_rx_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_sys,
    input  logic [7:0]  rx_data,
    input  logic        rx_vld,
    input  logic        rx_sop,
    input  logic        rx_eop,
    output logic        status_vld,
    output frame_stat_t frame_stat,
    output frame_len_t  stat_len,
    output logic [15:0] good_cnt,
    output logic [15:0] bad_cnt
);

    // Results handed to the status stage
    logic [31:0] crc_dout;
    logic        len_done;
    frame_len_t  frame_len;
    frame_stat_t len_class;

    // ====================
    // CRC over the whole frame
    // ====================

    fcs_calc fcs_calc_i (
        .clk_sys     (clk_sys),
        .rst_sys     (rst_sys),
        .crc_din     (rx_data),
        .crc_sop     (rx_sop),
        .crc_din_vld (rx_vld),
        .crc_cap     (rx_eop),
        .crc_dout    (crc_dout)
    );

    // ====================
    // Length check
    // ====================

    // Same byte strobes as the CRC path
    frame_length_check frame_length_check_i (
        .clk_sys   (clk_sys),
        .rst_sys   (rst_sys),
        .rx_vld    (rx_vld),
        .rx_sop    (rx_sop),
        .rx_eop    (rx_eop),
        .len_done  (len_done),
        .frame_len (frame_len),
        .len_class (len_class)
    );

    // ====================
    // Status and counters
    // ====================

    frame_status frame_status_i (
        .clk_sys    (clk_sys),
        .rst_sys    (rst_sys),
        .len_done   (len_done),
        .frame_len  (frame_len),
        .len_class  (len_class),
        .crc_dout   (crc_dout),
        .status_vld (status_vld),
        .frame_stat (frame_stat),
        .stat_len   (stat_len),
        .good_cnt   (good_cnt),
        .bad_cnt    (bad_cnt)
    );

endmodule

//--- eth_rx_macros.svh
`ifndef ETH_RX_MACROS_SVH
`define ETH_RX_MACROS_SVH

// ====================
// Frame length limits
// ====================

// Smallest legal frame in bytes, FCS included
`define ETH_MIN_LEN 64

// Largest legal frame in bytes, FCS included
`define ETH_MAX_LEN 1518

// Byte counter width
// Counter saturates at all ones (2047)
`define ETH_LEN_W 11

// ====================
// FCS check
// ====================

// Residue after a correct FCS, seen at crc_dout
// Same as 0xC704DD7B after inversion and per-byte bit reversal
`define FCS_GOOD_RESIDUE 32'h1CDF_4421

`endif

//--- eth_rx_pkg.sv
package eth_rx_pkg;

    `include "eth_rx_macros.svh"

    // ====================
    // Frame length
    // ====================

    // Byte count of one frame, FCS included
    typedef logic [`ETH_LEN_W-1:0] frame_len_t;

    // ====================
    // Frame status
    // ====================

    // Per-frame result code
    // Runt and giant come from the length check alone
    typedef enum logic [1:0] {
        FRM_GOOD    = 2'd0,
        FRM_BAD_FCS = 2'd1,
        FRM_RUNT    = 2'd2,
        FRM_GIANT   = 2'd3
    } frame_stat_t;

endpackage

//--- fcs_calc.sv
`timescale 1ns/1ns

module fcs_calc (
    input  logic        clk_sys,
    input  logic        rst_sys,
    input  logic [7:0]  crc_din,
    input  logic        crc_sop,
    input  logic        crc_din_vld,
    input  logic        crc_cap,
    output logic [31:0] crc_dout
);

    // CRC-32 seed and generator polynomial
    localparam logic [31:0] CRC_SEED = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;

    logic [7:0]  din_rev;
    logic [31:0] crc_reg;
    logic [31:0] crc_base;
    logic [31:0] crc_next;
    logic [31:0] cap_reg;
    logic [31:0] cap_inv;

    // ====================
    // Next-state equations
    // ====================

    // One byte through the MSB-first shift register
    // Loop unrolls into the parallel XOR equations
    function automatic logic [31:0] crc32_byte(
        input logic [31:0] crc_in,
        input logic [7:0]  d
    );
        logic [31:0] c;
        logic        fb;
        c = crc_in;
        // Bit 7 of the reversed byte goes in first
        for (int i = 7; i >= 0; i--) begin
            fb = c[31] ^ d[i];
            c  = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ CRC_POLY;
            end
        end
        return c;
    endfunction

    // Ethernet sends LSB first, so flip the byte
    for (genvar i = 0; i < 8; i++) begin : g_din_rev
        assign din_rev[i] = crc_din[7-i];
    end

    // First byte of a frame starts from the seed
    assign crc_base = crc_sop ? CRC_SEED : crc_reg;
    assign crc_next = crc32_byte(crc_base, din_rev);

    // ====================
    // Registers
    // ====================

    // Running CRC, advanced on every valid byte
    always_ff @(posedge clk_sys or posedge rst_sys) begin
        if (rst_sys) begin
            crc_reg <= CRC_SEED;
        end else if (crc_din_vld) begin
            crc_reg <= crc_next;
        end
    end

    // Capture includes the eop byte itself
    always_ff @(posedge clk_sys or posedge rst_sys) begin
        if (rst_sys) begin
            cap_reg <= '0;
        end else if (crc_din_vld && crc_cap) begin
            cap_reg <= crc_next;
        end
    end

    // ====================
    // Output transform
    // ====================

    // Invert, then reverse the bits inside each byte
    assign cap_inv = ~cap_reg;

    for (genvar i = 0; i < 32; i++) begin : g_dout_rev
        assign crc_dout[i] = cap_inv[8*(i/8) + 7 - (i%8)];
    end

    // Sop and capture strobes only come with a byte
    a_strobe_with_vld: assert property (
        @(posedge clk_sys) disable iff (rst_sys)
        (crc_sop || crc_cap) |-> crc_din_vld
    );

endmodule

//--- frame_length_check.sv
`timescale 1ns/1ns
`include "eth_rx_macros.svh"

module frame_length_check
    import eth_rx_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_sys,
    input  logic        rx_vld,
    input  logic        rx_sop,
    input  logic        rx_eop,
    output logic        len_done,
    output frame_len_t  frame_len,
    output frame_stat_t len_class
);

    // Counter stops at all ones
    localparam frame_len_t LEN_SAT = '1;

    logic       in_frame;
    frame_len_t byte_cnt;
    frame_len_t cnt_next;

    // ====================
    // Byte count
    // ====================

    // Count including the current byte
    // Sop restarts at one, even from saturation
    always_comb begin
        if (rx_sop) begin
            cnt_next = frame_len_t'(1);
        end else if (byte_cnt == LEN_SAT) begin
            cnt_next = byte_cnt;
        end else begin
            cnt_next = byte_cnt + frame_len_t'(1);
        end
    end

    // ====================
    // Registers
    // ====================

    always_ff @(posedge clk_sys or posedge rst_sys) begin
        if (rst_sys) begin
            in_frame  <= 1'b0;
            byte_cnt  <= '0;
            len_done  <= 1'b0;
            frame_len <= '0;
            len_class <= FRM_GOOD;
        end else begin
            // Pulse in the cycle after the eop byte
            len_done <= rx_vld && rx_eop;
            if (rx_vld) begin
                byte_cnt <= cnt_next;
                // Open until the eop byte
                in_frame <= !rx_eop;
                if (rx_eop) begin
                    frame_len <= cnt_next;
                    // Runt checked first
                    if (cnt_next < frame_len_t'(`ETH_MIN_LEN)) begin
                        len_class <= FRM_RUNT;
                    end else if (cnt_next > frame_len_t'(`ETH_MAX_LEN)) begin
                        len_class <= FRM_GIANT;
                    end else begin
                        len_class <= FRM_GOOD;
                    end
                end
            end
        end
    end

    // Bytes after the first only inside a frame
    a_byte_in_frame: assert property (
        @(posedge clk_sys) disable iff (rst_sys)
        (rx_vld && !rx_sop) |-> in_frame
    );

endmodule

//--- frame_status.sv
`timescale 1ns/1ns
`include "eth_rx_macros.svh"

module frame_status
    import eth_rx_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_sys,
    input  logic        len_done,
    input  frame_len_t  frame_len,
    input  frame_stat_t len_class,
    input  logic [31:0] crc_dout,
    output logic        status_vld,
    output frame_stat_t frame_stat,
    output frame_len_t  stat_len,
    output logic [15:0] good_cnt,
    output logic [15:0] bad_cnt
);

    logic        crc_ok;
    frame_stat_t stat_next;

    // ====================
    // Status merge
    // ====================

    // Residue compare on the captured CRC
    assign crc_ok = (crc_dout == `FCS_GOOD_RESIDUE);

    // Length class already holds runt over giant
    // A bad FCS only shows on a frame of legal length
    always_comb begin
        if (len_class != FRM_GOOD) begin
            stat_next = len_class;
        end else if (crc_ok) begin
            stat_next = FRM_GOOD;
        end else begin
            stat_next = FRM_BAD_FCS;
        end
    end

    // ====================
    // Pulse and counters
    // ====================

    always_ff @(posedge clk_sys or posedge rst_sys) begin
        if (rst_sys) begin
            status_vld <= 1'b0;
            good_cnt   <= '0;
            bad_cnt    <= '0;
        end else begin
            // One cycle after len_done
            status_vld <= len_done;
            if (len_done) begin
                // Both counters wrap
                if (stat_next == FRM_GOOD) begin
                    good_cnt <= good_cnt + 16'd1;
                end else begin
                    bad_cnt <= bad_cnt + 16'd1;
                end
            end
        end
    end

    // Result held until the next frame
    always_ff @(posedge clk_sys) begin
        if (len_done) begin
            frame_stat <= stat_next;
            stat_len   <= frame_len;
        end
    end

    // Single-cycle status strobe per frame
    a_status_pulse: assert property (
        @(posedge clk_sys) disable iff (rst_sys)
        status_vld |=> !status_vld
    );

endmodule

//--- project.f
+incdir+.
eth_rx_pkg.sv
fcs_calc.sv
frame_length_check.sv
frame_status.sv
eth_rx_check.sv
tb_clk_gen.sv
tb_checker.sv
tb_eth_rx_check.sv

//--- tb_checker.sv
`timescale 1ns/1ns
`include "eth_rx_macros.svh"

module tb_checker
    import eth_rx_pkg::*;
(
    input  logic        clk_sys,
    input  logic        rst_sys,
    input  logic [7:0]  rx_data,
    input  logic        rx_vld,
    input  logic        rx_sop,
    input  logic        rx_eop,
    input  logic        status_vld,
    input  frame_stat_t frame_stat,
    input  frame_len_t  stat_len,
    input  logic [15:0] good_cnt,
    input  logic [15:0] bad_cnt,
    input  logic        end_req,
    output logic        end_ack,
    output int          err_cnt,
    output int          pending,
    output int          frames_done,
    output int          good_tally,
    output int          bad_tally
);

    // Saturated length of the DUT counter
    localparam int LEN_SAT = (1 << `ETH_LEN_W) - 1;

    logic [7:0]  frm_buf [0:4095];
    int          buf_n;
    int          cyc;
    bit          rst_seen;

    // Expected results, oldest frame first
    frame_stat_t exp_stat_q [$];
    int          exp_len_q [$];
    int          exp_due_q [$];

    // ====================
    // Reference model
    // ====================

    // Reflected CRC-32 over all but the last four bytes
    // Then length rules, runt before giant before FCS
    function automatic frame_stat_t expect_status(input int n);
        logic [31:0] c;
        logic [31:0] fcs_rx;
        bit          crc_ok;
        c      = 32'hFFFF_FFFF;
        crc_ok = 1'b0;
        if (n >= 4) begin
            for (int i = 0; i < n - 4; i++) begin
                c = c ^ {24'd0, frm_buf[i]};
                for (int b = 0; b < 8; b++) begin
                    c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
                end
            end
            // FCS sits LSB first on the wire
            fcs_rx = {frm_buf[n-1], frm_buf[n-2], frm_buf[n-3], frm_buf[n-4]};
            crc_ok = (~c == fcs_rx);
        end
        if (n < `ETH_MIN_LEN) begin
            return FRM_RUNT;
        end
        if (n > `ETH_MAX_LEN) begin
            return FRM_GIANT;
        end
        return crc_ok ? FRM_GOOD : FRM_BAD_FCS;
    endfunction

    task automatic report_mismatch(input string sig, input int exp_v, input int act_v);
        $display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, sig, exp_v, act_v);
        err_cnt++;
    endtask

    // ====================
    // Status compare
    // ====================

    task automatic compare_status();
        frame_stat_t es;
        int          el;
        int          ed;
        es = exp_stat_q.pop_front();
        el = exp_len_q.pop_front();
        ed = exp_due_q.pop_front();
        frames_done++;
        if (es == FRM_GOOD) begin
            good_tally++;
        end else begin
            bad_tally++;
        end
        // Two edges after the eop byte
        if (ed != cyc) begin
            report_mismatch("status_vld cycle", ed, cyc);
        end
        if (frame_stat != es) begin
            $display("CHECK FAILED t=%0t frame_stat expected %s actual %s",
                     $time, es.name(), frame_stat.name());
            err_cnt++;
        end
        if (int'(stat_len) != el) begin
            report_mismatch("stat_len", el, int'(stat_len));
        end
        // Counters already include this frame
        if (int'(good_cnt) != good_tally % 65536) begin
            report_mismatch("good_cnt", good_tally % 65536, int'(good_cnt));
        end
        if (int'(bad_cnt) != bad_tally % 65536) begin
            report_mismatch("bad_cnt", bad_tally % 65536, int'(bad_cnt));
        end
    endtask

    initial begin
        end_ack     = 1'b0;
        err_cnt     = 0;
        pending     = 0;
        frames_done = 0;
        good_tally  = 0;
        bad_tally   = 0;
        buf_n       = 0;
        cyc         = 0;
        rst_seen    = 1'b0;
    end

    // Sampled on the falling edge, away from all updates
    always @(negedge clk_sys) begin
        cyc++;
        if (!rst_sys) begin
            // Counters right after reset
            if (!rst_seen) begin
                rst_seen = 1'b1;
                if (good_cnt != 16'd0) begin
                    report_mismatch("good_cnt", 0, int'(good_cnt));
                end
                if (bad_cnt != 16'd0) begin
                    report_mismatch("bad_cnt", 0, int'(bad_cnt));
                end
            end
            if (status_vld) begin
                if (exp_stat_q.size() == 0) begin
                    $display("Error at %0t: status_vld came with no frame waiting", $time);
                    err_cnt++;
                end else begin
                    compare_status();
                end
            end else if (exp_due_q.size() > 0 && exp_due_q[0] < cyc) begin
                $display("Error at %0t: no status_vld for the frame due in cycle %0d",
                         $time, exp_due_q[0]);
                err_cnt++;
                void'(exp_stat_q.pop_front());
                void'(exp_len_q.pop_front());
                void'(exp_due_q.pop_front());
            end
            // Frame bytes, restarted on sop
            if (rx_vld) begin
                if (rx_sop) begin
                    buf_n = 0;
                end
                if (buf_n < 4096) begin
                    frm_buf[buf_n] = rx_data;
                end
                buf_n++;
                if (rx_eop) begin
                    exp_stat_q.push_back(expect_status(buf_n));
                    exp_len_q.push_back((buf_n > LEN_SAT) ? LEN_SAT : buf_n);
                    exp_due_q.push_back(cyc + 2);
                end
            end
            pending = exp_stat_q.size();
            // Final counter and queue check
            if (end_req && !end_ack) begin
                if (exp_stat_q.size() != 0) begin
                    $display("Error at %0t: %0d frames never got a status",
                             $time, exp_stat_q.size());
                    err_cnt++;
                end
                if (int'(good_cnt) != good_tally % 65536) begin
                    report_mismatch("good_cnt", good_tally % 65536, int'(good_cnt));
                end
                if (int'(bad_cnt) != bad_tally % 65536) begin
                    report_mismatch("bad_cnt", bad_tally % 65536, int'(bad_cnt));
                end
                end_ack = 1'b1;
            end
        end
    end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen (
    output logic clk_sys,
    output logic rst_sys
);

    // 100 ns period
    localparam int HALF_PERIOD = 50;
    localparam int RST_CYCLES  = 5;

    initial begin
        clk_sys = 1'b0;
        forever #HALF_PERIOD clk_sys = ~clk_sys;
    end

    // Reset held for the first rising edges
    initial begin
        rst_sys = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_sys);
        rst_sys <= 1'b0;
    end

endmodule

//--- tb_eth_rx_check.sv
`timescale 1ns/1ns
`include "eth_rx_macros.svh"

module tb_eth_rx_check
    import eth_rx_pkg::*;
();

    logic        clk_sys;
    logic        rst_sys;
    logic [7:0]  rx_data;
    logic        rx_vld;
    logic        rx_sop;
    logic        rx_eop;
    logic        status_vld;
    frame_stat_t frame_stat;
    frame_len_t  stat_len;
    logic [15:0] good_cnt;
    logic [15:0] bad_cnt;
    logic        end_req;
    logic        end_ack;
    int          err_cnt;
    int          pending;
    int          frames_done;
    int          good_tally;
    int          bad_tally;

    // Frame plan, one entry per frame
    int          plan_len  [0:31];
    int          plan_flip [0:31];
    bit          plan_gap  [0:31];
    int          plan_idle [0:31];
    int          plan_test [0:31];
    int          n_plan;
    int          total_bytes;
    int          cycle_limit;
    int          cycle_cnt;
    logic [31:0] rng_state;
    logic [7:0]  frm [0:4095];

    tb_clk_gen clk_gen_i (
        .clk_sys (clk_sys),
        .rst_sys (rst_sys)
    );

    eth_rx_check eth_rx_check_i (
        .clk_sys    (clk_sys),
        .rst_sys    (rst_sys),
        .rx_data    (rx_data),
        .rx_vld     (rx_vld),
        .rx_sop     (rx_sop),
        .rx_eop     (rx_eop),
        .status_vld (status_vld),
        .frame_stat (frame_stat),
        .stat_len   (stat_len),
        .good_cnt   (good_cnt),
        .bad_cnt    (bad_cnt)
    );

    tb_checker checker_i (
        .clk_sys     (clk_sys),
        .rst_sys     (rst_sys),
        .rx_data     (rx_data),
        .rx_vld      (rx_vld),
        .rx_sop      (rx_sop),
        .rx_eop      (rx_eop),
        .status_vld  (status_vld),
        .frame_stat  (frame_stat),
        .stat_len    (stat_len),
        .good_cnt    (good_cnt),
        .bad_cnt     (bad_cnt),
        .end_req     (end_req),
        .end_ack     (end_ack),
        .err_cnt     (err_cnt),
        .pending     (pending),
        .frames_done (frames_done),
        .good_tally  (good_tally),
        .bad_tally   (bad_tally)
    );

    // ====================
    // Random and FCS
    // ====================

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] span;
        span = 32'(hi - lo + 1);
        return lo + int'(next_random() % span);
    endfunction

    // Reflected CRC-32 over the first n bytes
    function automatic logic [31:0] fcs_of(input int n);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        for (int i = 0; i < n; i++) begin
            c = c ^ {24'd0, frm[i]};
            for (int b = 0; b < 8; b++) begin
                c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
            end
        end
        return ~c;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1: return "good frames";
            2: return "bad FCS";
            3: return "runt frames";
            4: return "giant frames";
            default: return "gaps and back to back";
        endcase
    endfunction

    // ====================
    // Frame plan
    // ====================

    task automatic add_frame(input int t, input int len, input int flip, input bit gap,
                             input int idle);
        plan_test[n_plan] = t;
        plan_len[n_plan]  = len;
        plan_flip[n_plan] = flip;
        plan_gap[n_plan]  = gap;
        plan_idle[n_plan] = idle;
        total_bytes += len + idle;
        n_plan++;
    endtask

    task automatic build_plan();
        int len;
        // Legal lengths, edges included
        add_frame(1, `ETH_MIN_LEN, -1, 1'b0, 3);
        add_frame(1, `ETH_MAX_LEN, -1, 1'b0, 3);
        for (int i = 0; i < 3; i++) begin
            add_frame(1, rand_range(`ETH_MIN_LEN, `ETH_MAX_LEN), -1, 1'b0, 3);
        end
        // One flipped byte in payload, then in FCS
        len = rand_range(`ETH_MIN_LEN, `ETH_MAX_LEN);
        add_frame(2, len, rand_range(0, len - 5), 1'b0, 3);
        len = rand_range(`ETH_MIN_LEN, `ETH_MAX_LEN);
        add_frame(2, len, rand_range(len - 4, len - 1), 1'b0, 3);
        add_frame(2, `ETH_MIN_LEN, 0, 1'b0, 3);
        // Short frames, sop and eop together on the first
        add_frame(3, 1, -1, 1'b0, 3);
        add_frame(3, 20, -1, 1'b0, 3);
        add_frame(3, `ETH_MIN_LEN - 1, -1, 1'b0, 3);
        // Long frames up to and past saturation
        add_frame(4, `ETH_MAX_LEN + 1, -1, 1'b0, 3);
        add_frame(4, rand_range(`ETH_MAX_LEN + 2, 2046), -1, 1'b0, 3);
        add_frame(4, 2047, -1, 1'b0, 3);
        add_frame(4, 2100, -1, 1'b0, 3);
        // No idle between frames, rx_vld gaps inside
        for (int i = 0; i < 6; i++) begin
            add_frame(5, (i == 3) ? rand_range(8, 63) : rand_range(64, 300),
                      (i == 4) ? 10 : -1, 1'b1, (i == 5) ? 3 : 0);
        end
    endtask

    // ====================
    // Stimulus
    // ====================

    task automatic drive_idle();
        @(posedge clk_sys);
        rx_vld <= 1'b0;
        rx_sop <= 1'b0;
        rx_eop <= 1'b0;
    endtask

    task automatic send_frame(input int idx);
        int          len;
        logic [31:0] r;
        logic [31:0] fcs;
        len = plan_len[idx];
        for (int i = 0; i < len; i++) begin
            r      = next_random();
            frm[i] = r[7:0];
        end
        // FCS appended LSB first
        if (len >= 4) begin
            fcs        = fcs_of(len - 4);
            frm[len-4] = fcs[7:0];
            frm[len-3] = fcs[15:8];
            frm[len-2] = fcs[23:16];
            frm[len-1] = fcs[31:24];
        end
        if (plan_flip[idx] >= 0) begin
            frm[plan_flip[idx]] = frm[plan_flip[idx]] ^ 8'h10;
        end
        for (int i = 0; i < len; i++) begin
            // Pause the frame now and then
            if (plan_gap[idx] && i > 0 && rand_range(0, 3) == 0) begin
                drive_idle();
            end
            @(posedge clk_sys);
            rx_data <= frm[i];
            rx_vld  <= 1'b1;
            rx_sop  <= (i == 0);
            rx_eop  <= (i == len - 1);
        end
        for (int k = 0; k < plan_idle[idx]; k++) begin
            drive_idle();
        end
    endtask

    initial begin
        int err_before;
        rx_data     = 8'd0;
        rx_vld      = 1'b0;
        rx_sop      = 1'b0;
        rx_eop      = 1'b0;
        end_req     = 1'b0;
        cycle_cnt   = 0;
        n_plan      = 0;
        total_bytes = 0;
        rng_state   = 32'd67;
        build_plan();
        // Gaps at most double the byte count
        cycle_limit = total_bytes * 2 + 1000;
        @(negedge rst_sys);
        @(posedge clk_sys);
        for (int t = 1; t <= 5; t++) begin
            err_before = err_cnt;
            for (int i = 0; i < n_plan; i++) begin
                if (plan_test[i] == t) begin
                    send_frame(i);
                end
            end
            while (pending != 0) begin
                @(posedge clk_sys);
            end
            $display("test %0d %s: %s, %0d errors", t, test_name(t),
                     (err_cnt == err_before) ? "ok" : "errors found", err_cnt - err_before);
        end
        @(posedge clk_sys);
        end_req <= 1'b1;
        while (!end_ack) begin
            @(posedge clk_sys);
        end
        $display("frames %0d, good %0d, bad %0d, errors %0d",
                 frames_done, good_tally, bad_tally, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Run limit from the planned byte count
    always @(posedge clk_sys) begin
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
        end
    end

endmodule
